//--- files.f
+incdir+testbench
rtl/apb_pkg.sv
rtl/mtimer_pkg.sv
rtl/apb_slot_decoder.sv
rtl/mtime_counter.sv
rtl/mtimer_regs.sv
rtl/mtimer_subsystem.sv
testbench/mtimer_tb.sv

//--- rtl/apb_pkg.sv
// APB bus types shared by every bus-facing block of the machine timer peripheral
`default_nettype none

package apb_pkg;

	// ----------------------------------------------------------------------
	// bus widths
	// ----------------------------------------------------------------------

	localparam int APB_ADDR_W = 16;
	localparam int APB_DATA_W = 32;

	// region number of the timer slot
	localparam logic [1:0] REGION_TIMER = 2'd0;

	// ----------------------------------------------------------------------
	// address word
	// ----------------------------------------------------------------------

	// the decoder looks at the top two bits, the register file at the rest
	typedef union packed {
		logic [APB_ADDR_W-1:0] flat;
		struct packed {
			logic [1:0]  region;
			logic [13:0] offset;
		} split;
	} apb_addr_t;

	// ----------------------------------------------------------------------
	// request and response
	// ----------------------------------------------------------------------

	// driven by the master, setup then access cycle
	typedef struct packed {
		logic                  psel;
		logic                  penable;
		logic                  pwrite;
		apb_addr_t             paddr;
		logic [APB_DATA_W-1:0] pwdata;
	} apb_req_t;

	// valid in the access cycle only
	typedef struct packed {
		logic [APB_DATA_W-1:0] prdata;
		logic                  pready;
		logic                  pslverr;
	} apb_rsp_t;

endpackage

`default_nettype wire

//--- rtl/apb_slot_decoder.sv
// APB slot decoder that forwards timer-region accesses and answers other regions with an error
`timescale 1ns/1ps
`default_nettype none

module apb_slot_decoder (
	input  logic              clk,
	input  logic              rst_n,

	// from the bus master
	input  apb_pkg::apb_req_t apb_req,
	output apb_pkg::apb_rsp_t apb_rsp,

	// to the timer register file
	output apb_pkg::apb_req_t tmr_req,
	input  apb_pkg::apb_rsp_t tmr_rsp
);

	// ----------------------------------------------------------------------
	// region decode
	// ----------------------------------------------------------------------

	logic hit_timer;
	logic access;

	assign hit_timer = (apb_req.paddr.split.region == apb_pkg::REGION_TIMER);

	// access cycle of the current transfer
	assign access = apb_req.psel & apb_req.penable;

	// ----------------------------------------------------------------------
	// request routing
	// ----------------------------------------------------------------------

	always_comb begin
		tmr_req      = apb_req;
		// timer only sees its own region
		tmr_req.psel = apb_req.psel & hit_timer;
	end

	// ----------------------------------------------------------------------
	// response mux
	// ----------------------------------------------------------------------

	always_comb begin
		if (hit_timer) begin
			apb_rsp = tmr_rsp;
		end else begin
			// unmapped region, complete at once with an error
			apb_rsp.prdata  = '0;
			apb_rsp.pready  = access;
			apb_rsp.pslverr = access;
		end
	end

	// ----------------------------------------------------------------------
	// checks
	// ----------------------------------------------------------------------

	// an access cycle always follows a setup cycle of the same transfer
	penable_after_psel: assert property (
		@(posedge clk) disable iff (!rst_n)
		apb_req.penable |-> $past(apb_req.psel)
	) else $error("penable high without psel in the previous cycle");

endmodule

`default_nettype wire

//--- rtl/mtime_counter.sv
// Microsecond prescaler and 64-bit mtime counter with software load and debug halt freeze
`timescale 1ns/1ps
`default_nettype none

module mtime_counter (
	input  logic                     clk,
	input  logic                     rst_n,

	input  logic                     enable,
	input  logic                     dbg_halt,
	input  mtimer_pkg::mtime_load_t  load,

	output mtimer_pkg::mtime_t       mtime
);

	// ----------------------------------------------------------------------
	// microsecond timebase
	// ----------------------------------------------------------------------

	logic [mtimer_pkg::TICK_CNT_W-1:0] tick_ctr;
	logic                              tick;

	// free running, never stopped by enable or halt
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tick_ctr <= mtimer_pkg::TICK_RELOAD;
		end else if (tick) begin
			tick_ctr <= mtimer_pkg::TICK_RELOAD;
		end else begin
			tick_ctr <= tick_ctr - 1'b1;
		end
	end

	assign tick = (tick_ctr == '0);

	// ----------------------------------------------------------------------
	// mtime
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtime <= '0;
		end else if (load.load_lo || load.load_hi) begin
			// a load wins over a tick in the same cycle
			if (load.load_lo) begin
				mtime[31:0] <= load.value[31:0];
			end
			if (load.load_hi) begin
				mtime[63:32] <= load.value[63:32];
			end
		end else if (tick && enable && !dbg_halt) begin
			mtime <= mtime + 64'd1;
		end
	end

	// ----------------------------------------------------------------------
	// checks
	// ----------------------------------------------------------------------

	// one APB write loads one half only
	single_half_load: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(load.load_lo && load.load_hi)
	) else $error("both halves of mtime loaded in one cycle");

endmodule

`default_nettype wire

//--- rtl/mtimer_pkg.sv
// Machine timer constants and types used by the register file and the mtime counter
`default_nettype none

package mtimer_pkg;

	// ----------------------------------------------------------------------
	// timebase
	// ----------------------------------------------------------------------

	// system clock in MHz, one tick per microsecond
	localparam int CLK_MHZ    = 27;
	localparam int TICK_CNT_W = $clog2(CLK_MHZ);

	// prescaler counts down from here to zero
	localparam logic [TICK_CNT_W-1:0] TICK_RELOAD = TICK_CNT_W'(CLK_MHZ - 1);

	typedef logic [63:0] mtime_t;

	// ----------------------------------------------------------------------
	// register map
	// ----------------------------------------------------------------------

	// byte offsets inside the timer slot
	localparam logic [13:0] OFS_CTRL        = 14'h00;
	localparam logic [13:0] OFS_MTIME_LO    = 14'h08;
	localparam logic [13:0] OFS_MTIME_HI    = 14'h0c;
	localparam logic [13:0] OFS_MTIMECMP_LO = 14'h10;
	localparam logic [13:0] OFS_MTIMECMP_HI = 14'h14;

	// compare never matches until software programs it
	localparam mtime_t MTIMECMP_RESET = '1;

	// ----------------------------------------------------------------------
	// counter load
	// ----------------------------------------------------------------------

	// one-cycle strobes, each one selects its own half of value
	typedef struct packed {
		logic   load_lo;
		logic   load_hi;
		mtime_t value;
	} mtime_load_t;

endpackage

`default_nettype wire

//--- rtl/mtimer_regs.sv
// Timer register file with ctrl, mtime load strobes, mtimecmp and the registered interrupt
`timescale 1ns/1ps
`default_nettype none

module mtimer_regs (
	input  logic                     clk,
	input  logic                     rst_n,

	// timer slot of the bus
	input  apb_pkg::apb_req_t        tmr_req,
	output apb_pkg::apb_rsp_t        tmr_rsp,

	// counter control
	output mtimer_pkg::mtime_load_t  load,
	output logic                     enable,
	input  mtimer_pkg::mtime_t       mtime,

	output logic                     timer_irq
);

	// ----------------------------------------------------------------------
	// access decode
	// ----------------------------------------------------------------------

	logic        access;
	logic        wr_en;
	logic [13:0] offset;

	assign access = tmr_req.psel & tmr_req.penable;
	assign wr_en  = access & tmr_req.pwrite;
	assign offset = tmr_req.paddr.split.offset;

	// ----------------------------------------------------------------------
	// ctrl and mtimecmp
	// ----------------------------------------------------------------------

	mtimer_pkg::mtime_t mtimecmp;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			enable   <= 1'b0;
			mtimecmp <= mtimer_pkg::MTIMECMP_RESET;
		end else if (wr_en) begin
			case (offset)
				mtimer_pkg::OFS_CTRL:        enable          <= tmr_req.pwdata[0];
				mtimer_pkg::OFS_MTIMECMP_LO: mtimecmp[31:0]  <= tmr_req.pwdata;
				mtimer_pkg::OFS_MTIMECMP_HI: mtimecmp[63:32] <= tmr_req.pwdata;
				default: ;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// mtime load strobes
	// ----------------------------------------------------------------------

	logic               load_lo_q;
	logic               load_hi_q;
	mtimer_pkg::mtime_t load_value_q;

	// strobes land in the cycle after the access so the counter loads one later
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			load_lo_q <= 1'b0;
			load_hi_q <= 1'b0;
		end else begin
			load_lo_q <= wr_en && (offset == mtimer_pkg::OFS_MTIME_LO);
			load_hi_q <= wr_en && (offset == mtimer_pkg::OFS_MTIME_HI);
		end
	end

	// each half keeps the last data written to it
	always_ff @(posedge clk) begin
		if (wr_en && offset == mtimer_pkg::OFS_MTIME_LO) begin
			load_value_q[31:0] <= tmr_req.pwdata;
		end
		if (wr_en && offset == mtimer_pkg::OFS_MTIME_HI) begin
			load_value_q[63:32] <= tmr_req.pwdata;
		end
	end

	assign load = '{load_lo: load_lo_q, load_hi: load_hi_q, value: load_value_q};

	// ----------------------------------------------------------------------
	// read back
	// ----------------------------------------------------------------------

	always_comb begin
		case (offset)
			mtimer_pkg::OFS_CTRL:        tmr_rsp.prdata = {31'd0, enable};
			mtimer_pkg::OFS_MTIME_LO:    tmr_rsp.prdata = mtime[31:0];
			mtimer_pkg::OFS_MTIME_HI:    tmr_rsp.prdata = mtime[63:32];
			mtimer_pkg::OFS_MTIMECMP_LO: tmr_rsp.prdata = mtimecmp[31:0];
			mtimer_pkg::OFS_MTIMECMP_HI: tmr_rsp.prdata = mtimecmp[63:32];
			// holes in the map read as zero
			default:                     tmr_rsp.prdata = '0;
		endcase
		// no wait states and no errors inside the slot
		tmr_rsp.pready  = access;
		tmr_rsp.pslverr = 1'b0;
	end

	// ----------------------------------------------------------------------
	// interrupt
	// ----------------------------------------------------------------------

	// level interrupt, one cycle behind the compare inputs
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			timer_irq <= 1'b0;
		end else begin
			timer_irq <= (mtime >= mtimecmp);
		end
	end

	// counter and compare reset values must keep the line quiet
	irq_quiet_after_reset: assert property (
		@(posedge clk)
		$rose(rst_n) |=> !timer_irq
	) else $error("timer_irq high right after reset release");

endmodule

`default_nettype wire

//--- rtl/mtimer_subsystem.sv
// Top of the machine timer peripheral, instantiated with one APB slave port and a debug halt input
`timescale 1ns/1ps
`default_nettype none

module mtimer_subsystem (
	input  logic              clk,
	input  logic              rst_n,

	input  apb_pkg::apb_req_t apb_req,
	output apb_pkg::apb_rsp_t apb_rsp,

	// hart halted by the debugger
	input  logic              dbg_halt,
	output logic              timer_irq
);

	// ----------------------------------------------------------------------
	// internal wiring
	// ----------------------------------------------------------------------

	apb_pkg::apb_req_t       tmr_req;
	apb_pkg::apb_rsp_t       tmr_rsp;
	mtimer_pkg::mtime_load_t load;
	logic                    enable;
	mtimer_pkg::mtime_t      mtime;

	// bus side
	apb_slot_decoder u_decoder (
		.clk     (clk),
		.rst_n   (rst_n),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.tmr_req (tmr_req),
		.tmr_rsp (tmr_rsp)
	);

	// registers, compare and interrupt
	mtimer_regs u_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.tmr_req   (tmr_req),
		.tmr_rsp   (tmr_rsp),
		.load      (load),
		.enable    (enable),
		.mtime     (mtime),
		.timer_irq (timer_irq)
	);

	// timebase and mtime
	mtime_counter u_counter (
		.clk      (clk),
		.rst_n    (rst_n),
		.enable   (enable),
		.dbg_halt (dbg_halt),
		.load     (load),
		.mtime    (mtime)
	);

endmodule

`default_nettype wire

//--- testbench/mtimer_tb_checks.svh
// APB access tasks and typed compare tasks, included inside the timer testbench module
`ifndef MTIMER_TB_CHECKS_SVH
`define MTIMER_TB_CHECKS_SVH

// ----------------------------------------------------------------------
// compare tasks
// ----------------------------------------------------------------------

task automatic check_rsp(input apb_pkg::apb_rsp_t got, input apb_pkg::apb_rsp_t want,
		input bit with_data, input string what);
	if (got.pready !== want.pready || got.pslverr !== want.pslverr
			|| (with_data && got.prdata !== want.prdata)) begin
		fail_check($sformatf("%s, got data %h ready %b err %b, expected %h %b %b", what,
			got.prdata, got.pready, got.pslverr, want.prdata, want.pready, want.pslverr));
	end
endtask

task automatic check_time(input mtimer_pkg::mtime_t got, input mtimer_pkg::mtime_t lo_bound,
		input mtimer_pkg::mtime_t hi_bound, input string what);
	if ($isunknown(got) || got < lo_bound || got > hi_bound) begin
		fail_check($sformatf("%s, mtime %h outside %h to %h", what, got, lo_bound, hi_bound));
	end
endtask

task automatic check_irq(input logic got, input logic want, input string what);
	if (got !== want) begin
		fail_check($sformatf("%s, timer_irq %b expected %b", what, got, want));
	end
endtask

// ----------------------------------------------------------------------
// bus access
// ----------------------------------------------------------------------

// setup, access, then idle again on the next falling edge
task automatic apb_transfer(input logic write, input logic [1:0] region,
		input logic [13:0] ofs, input logic [31:0] wdata,
		output apb_pkg::apb_rsp_t rsp, output int unsigned at);
	@(negedge clk);
	apb_req.psel               = 1'b1;
	apb_req.penable            = 1'b0;
	apb_req.pwrite             = write;
	apb_req.paddr.split.region = region;
	apb_req.paddr.split.offset = ofs;
	apb_req.pwdata             = wdata;
	@(negedge clk);
	apb_req.penable = 1'b1;
	// response is settled a quarter period later
	#(CLK_PERIOD / 4);
	rsp = apb_rsp;
	at  = cycle_cnt;
	@(negedge clk);
	apb_req.psel    = 1'b0;
	apb_req.penable = 1'b0;
endtask

task automatic write_reg(input logic [13:0] ofs, input logic [31:0] data,
		output int unsigned at);
	apb_pkg::apb_rsp_t rsp;
	apb_pkg::apb_rsp_t want;
	apb_transfer(1'b1, apb_pkg::REGION_TIMER, ofs, data, rsp, at);
	want        = '0;
	want.pready = 1'b1;
	check_rsp(rsp, want, 1'b0, $sformatf("write of offset %h", ofs));
	update_model(ofs, data);
endtask

task automatic read_reg(input logic [13:0] ofs, input bit with_data,
		output logic [31:0] data, output int unsigned at);
	apb_pkg::apb_rsp_t rsp;
	apb_pkg::apb_rsp_t want;
	apb_transfer(1'b0, apb_pkg::REGION_TIMER, ofs, '0, rsp, at);
	want.prdata  = ref_read(ofs);
	want.pready  = 1'b1;
	want.pslverr = 1'b0;
	check_rsp(rsp, want, with_data, $sformatf("read of offset %h", ofs));
	data = rsp.prdata;
endtask

// low half first, its access cycle is the sample point
task automatic read_mtime(output mtimer_pkg::mtime_t t, output int unsigned at);
	logic [31:0] lo;
	logic [31:0] hi;
	int unsigned at_hi;
	read_reg(mtimer_pkg::OFS_MTIME_LO, 1'b0, lo, at);
	read_reg(mtimer_pkg::OFS_MTIME_HI, 1'b0, hi, at_hi);
	t = {hi, lo};
endtask

`endif

//--- testbench/mtimer_tb.sv
// Self-checking testbench for the machine timer peripheral, run as the simulation top
`timescale 1ns/1ps
`default_nettype none

module mtimer_tb;

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 8;
	// reset, read-back, unmapped, counting, halt, interrupt
	localparam int TEST_CYCLES  = RESET_CYCLES + 20 + 120 + 50 + 450 + 600 + 40;

	logic              clk;
	logic              rst_n;
	logic              dbg_halt;
	logic              timer_irq;
	apb_pkg::apb_req_t apb_req;
	apb_pkg::apb_rsp_t apb_rsp;
	int unsigned       cycle_cnt;

	// expected register state
	logic               model_ctrl;
	mtimer_pkg::mtime_t model_cmp;
	mtimer_pkg::mtime_t model_time;

	mtimer_subsystem dut0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.apb_req   (apb_req),
		.apb_rsp   (apb_rsp),
		.dbg_halt  (dbg_halt),
		.timer_irq (timer_irq)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	initial begin
		#(4 * TEST_CYCLES * CLK_PERIOD);
		$display("ERROR: timeout, the tests did not finish within %0d cycles", 4 * TEST_CYCLES);
		abort_run();
	end

	task automatic abort_run();
		$display("Testbench failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic fail_check(input string msg);
		$display("FAIL %0t: %s", $time, msg);
		abort_run();
	endtask

	// ----------------------------------------------------------------------
	// reference model
	// ----------------------------------------------------------------------

	task automatic update_model(input logic [13:0] ofs, input logic [31:0] data);
		case (ofs)
			mtimer_pkg::OFS_CTRL:        model_ctrl        = data[0];
			mtimer_pkg::OFS_MTIME_LO:    model_time[31:0]  = data;
			mtimer_pkg::OFS_MTIME_HI:    model_time[63:32] = data;
			mtimer_pkg::OFS_MTIMECMP_LO: model_cmp[31:0]   = data;
			mtimer_pkg::OFS_MTIMECMP_HI: model_cmp[63:32]  = data;
			default: ;
		endcase
	endtask

	// mtime reads the last loaded value while stopped
	function automatic logic [31:0] ref_read(input logic [13:0] ofs);
		case (ofs)
			mtimer_pkg::OFS_CTRL:        return {31'd0, model_ctrl};
			mtimer_pkg::OFS_MTIME_LO:    return model_time[31:0];
			mtimer_pkg::OFS_MTIME_HI:    return model_time[63:32];
			mtimer_pkg::OFS_MTIMECMP_LO: return model_cmp[31:0];
			mtimer_pkg::OFS_MTIMECMP_HI: return model_cmp[63:32];
			default:                     return 32'd0;
		endcase
	endfunction

	// one tick per CLK_MHZ cycles, one tick of slack either way
	function automatic mtimer_pkg::mtime_t ref_time(input mtimer_pkg::mtime_t base,
			input int unsigned w, input bit upper);
		mtimer_pkg::mtime_t ticks;
		ticks = w / mtimer_pkg::CLK_MHZ;
		return upper ? base + ticks + 64'd1 : base + ticks - 64'd1;
	endfunction

`include "mtimer_tb_checks.svh"

	task automatic check_registers();
		logic [31:0] rd;
		int unsigned at;
		read_reg(mtimer_pkg::OFS_CTRL, 1'b1, rd, at);
		read_reg(mtimer_pkg::OFS_MTIMECMP_LO, 1'b1, rd, at);
		read_reg(mtimer_pkg::OFS_MTIMECMP_HI, 1'b1, rd, at);
		read_reg(mtimer_pkg::OFS_MTIME_LO, 1'b1, rd, at);
		read_reg(mtimer_pkg::OFS_MTIME_HI, 1'b1, rd, at);
	endtask

	// ----------------------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------------------

	initial begin
		mtimer_pkg::mtime_t t0;
		mtimer_pkg::mtime_t t1;
		logic [31:0]        rd;
		int unsigned        at0;
		int unsigned        at1;
		apb_pkg::apb_rsp_t  rsp;
		apb_pkg::apb_rsp_t  want;
		void'($urandom(46114));
		apb_req    = '0;
		dbg_halt   = 1'b0;
		rst_n      = 1'b0;
		model_ctrl = 1'b0;
		model_cmp  = mtimer_pkg::MTIMECMP_RESET;
		model_time = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;

		// reset state
		@(negedge clk);
		check_irq(timer_irq, 1'b0, "irq after reset");
		check_registers();

		// read-back of random values
		repeat (4) begin
			write_reg(mtimer_pkg::OFS_MTIMECMP_LO, $urandom(), at0);
			write_reg(mtimer_pkg::OFS_MTIMECMP_HI, $urandom(), at0);
			write_reg(mtimer_pkg::OFS_CTRL, $urandom(), at0);
			read_reg(mtimer_pkg::OFS_MTIMECMP_LO, 1'b1, rd, at0);
			read_reg(mtimer_pkg::OFS_MTIMECMP_HI, 1'b1, rd, at0);
			read_reg(mtimer_pkg::OFS_CTRL, 1'b1, rd, at0);
		end
		write_reg(mtimer_pkg::OFS_CTRL, 32'd0, at0);
		write_reg(mtimer_pkg::OFS_MTIME_LO, $urandom(), at0);
		write_reg(mtimer_pkg::OFS_MTIME_HI, $urandom(), at0);
		check_registers();

		// unmapped regions answer with an error and leave the timer alone
		want         = '0;
		want.pready  = 1'b1;
		want.pslverr = 1'b1;
		for (int r = 1; r < 4; r++) begin
			apb_transfer(1'b1, 2'(r), 14'($urandom_range(0, 5) * 4), $urandom(), rsp, at0);
			check_rsp(rsp, want, 1'b1, "unmapped write");
			apb_transfer(1'b0, 2'(r), 14'($urandom_range(0, 5) * 4), '0, rsp, at0);
			check_rsp(rsp, want, 1'b1, "unmapped read");
		end
		check_registers();

		// counting from a loaded value, low half kept clear of a carry
		write_reg(mtimer_pkg::OFS_MTIME_LO, $urandom() & 32'h0fff_ffff, at0);
		write_reg(mtimer_pkg::OFS_MTIME_HI, $urandom(), at0);
		write_reg(mtimer_pkg::OFS_CTRL, 32'd1, at0);
		repeat ($urandom_range(100, 400)) @(negedge clk);
		read_mtime(t1, at1);
		check_time(t1, ref_time(model_time, at1 - at0, 1'b0),
			ref_time(model_time, at1 - at0, 1'b1), "mtime after counting");

		// debug halt freezes mtime, release resumes counting
		dbg_halt = 1'b1;
		read_mtime(t0, at0);
		repeat (5 * mtimer_pkg::CLK_MHZ) @(negedge clk);
		read_mtime(t1, at1);
		check_time(t1, t0, t0, "mtime during debug halt");
		@(negedge clk);
		dbg_halt = 1'b0;
		at0      = cycle_cnt;
		repeat ($urandom_range(100, 400)) @(negedge clk);
		read_mtime(t1, at1);
		check_time(t1, ref_time(t0, at1 - at0, 1'b0), ref_time(t0, at1 - at0, 1'b1),
			"mtime after debug release");

		// compare at or below mtime raises the line, all ones clears it
		read_mtime(t0, at0);
		write_reg(mtimer_pkg::OFS_MTIMECMP_LO, 32'd0, at0);
		write_reg(mtimer_pkg::OFS_MTIMECMP_HI, t0[63:32], at0);
		repeat (2) @(negedge clk);
		check_irq(timer_irq, 1'b1, "irq with mtimecmp at or below mtime");
		write_reg(mtimer_pkg::OFS_MTIMECMP_LO, 32'hffff_ffff, at0);
		write_reg(mtimer_pkg::OFS_MTIMECMP_HI, 32'hffff_ffff, at0);
		repeat (2) @(negedge clk);
		check_irq(timer_irq, 1'b0, "irq with mtimecmp all ones");

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire
